//--- logic/evict_macros.svh
`ifndef EVICT_MACROS_SVH
`define EVICT_MACROS_SVH

// bus widths
`define EVICT_ADDR_W		32
`define EVICT_DATA_W		64
`define EVICT_ID_W		4

// entries per eviction FIFO
`define EVICT_FIFO_DEPTH	8

// writes that may await B at once
`define EVICT_MAX_OUTST		4
`define EVICT_OUTST_W		($clog2(`EVICT_MAX_OUTST + 1))

`define EVICT_ERR_W		16

`endif

//--- logic/evict_pkg.sv
`default_nettype none

package evict_pkg;

	// issuer FSM
	typedef enum logic [1:0] {
		S_IDLE,
		S_POP,
		S_SEND
	} issuer_state_e;

	// AXI BRESP encoding
	typedef enum logic [1:0] {
		RESP_OKAY	= 2'b00,
		RESP_EXOKAY	= 2'b01,
		RESP_SLVERR	= 2'b10,
		RESP_DECERR	= 2'b11
	} axi_resp_e;

endpackage

`default_nettype wire

//--- logic/evict_trk_if.sv
`default_nettype none
`include "evict_macros.svh"

interface evict_trk_if;

	logic				credit;		// a write may start now
	logic	[`EVICT_ID_W-1:0]	next_id;	// lowest free id
	logic				issue;		// one cycle per sent write
	logic	[`EVICT_ID_W-1:0]	issue_id;

	modport issuer (
		input	credit, next_id,
		output	issue, issue_id
	);

	modport tracker (
		output	credit, next_id,
		input	issue, issue_id
	);

endinterface

`default_nettype wire

//--- logic/evict_fifo.sv
`default_nettype none

module evict_fifo #(
	parameter int WIDTH	= 32,
	parameter int DEPTH	= 8
) (
	input	wire			clk,
	input	wire			rst_n,
	input	wire			push_i,
	input	wire	[WIDTH-1:0]	push_data_i,
	output	logic			ready_o,
	input	wire			rden_i,
	output	logic			empty_o,
	output	logic	[WIDTH-1:0]	data_o
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

logic	[WIDTH-1:0]	mem [DEPTH];
logic	[PTR_W-1:0]	wr_ptr;
logic	[PTR_W-1:0]	rd_ptr;
logic	[CNT_W-1:0]	count;

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
	if (ptr == PTR_W'(DEPTH - 1)) begin
		return '0;	// wrap, depth need not be a power of two
	end
	return ptr + 1'b1;
endfunction

assign ready_o = (count != CNT_W'(DEPTH));
assign empty_o = (count == '0);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		wr_ptr	<= '0;
		rd_ptr	<= '0;
		count	<= '0;
	end else begin
		if (push_i)
			wr_ptr <= ptr_inc(wr_ptr);
		if (rden_i)
			rd_ptr <= ptr_inc(rd_ptr);
		case ({push_i, rden_i})
			2'b10:		count <= count + 1'b1;
			2'b01:		count <= count - 1'b1;
			default:	;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (push_i)
		mem[wr_ptr] <= push_data_i;
	if (rden_i)
		data_o <= mem[rd_ptr];	// entry shows up next cycle
end

// push side is gated by ready at the top, pop side by the issuer
a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
	push_i |-> ready_o);
a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
	rden_i |-> !empty_o);

endmodule

`default_nettype wire

//--- logic/evict_issuer.sv
`default_nettype none
`include "evict_macros.svh"

module evict_issuer
	import evict_pkg::*;
(
	input	wire				clk,
	input	wire				rst_n,

	// address FIFO read side
	input	wire				awfifo_empty_i,
	output	logic				awfifo_rden_o,
	input	wire	[`EVICT_ADDR_W-1:0]	awfifo_data_i,

	// data FIFO read side
	input	wire				wfifo_empty_i,
	output	logic				wfifo_rden_o,
	input	wire	[`EVICT_DATA_W-1:0]	wfifo_data_i,

	evict_trk_if.issuer			trk,

	// AW channel
	output	logic	[`EVICT_ID_W-1:0]	awid_o,
	output	logic	[`EVICT_ADDR_W-1:0]	awaddr_o,
	output	logic				awvalid_o,
	input	wire				awready_i,

	// W channel
	output	logic	[`EVICT_ID_W-1:0]	wid_o,
	output	logic	[`EVICT_DATA_W-1:0]	wdata_o,
	output	logic				wvalid_o,
	input	wire				wready_i
);

issuer_state_e			state;
issuer_state_e			state_n;

logic				pop_go;
logic				aw_done;
logic				w_done;

logic				awvalid_q;
logic				wvalid_q;
logic				issue_q;

logic	[`EVICT_ID_W-1:0]	id_q;
logic	[`EVICT_ADDR_W-1:0]	awaddr_q;
logic	[`EVICT_DATA_W-1:0]	wdata_q;

// credit only matters while idle
assign pop_go = (state == S_IDLE) && !awfifo_empty_i && !wfifo_empty_i && trk.credit;

// channel finished already or finishing now
assign aw_done	= !awvalid_q || awready_i;
assign w_done	= !wvalid_q || wready_i;

always_comb begin
	state_n = state;
	case (state)
		S_IDLE: begin
			if (pop_go)
				state_n = S_POP;
		end
		S_POP: begin
			state_n = S_SEND;	// FIFO outputs valid now
		end
		S_SEND: begin
			if (aw_done && w_done)
				state_n = S_IDLE;
		end
		default: begin
			state_n = S_IDLE;
		end
	endcase
end

always_ff @(posedge clk) begin
	if (!rst_n) begin
		state		<= S_IDLE;
		awvalid_q	<= 1'b0;
		wvalid_q	<= 1'b0;
		issue_q		<= 1'b0;
	end else begin
		state	<= state_n;
		issue_q	<= (state == S_POP);	// high on first S_SEND cycle
		if (state == S_POP) begin
			awvalid_q	<= 1'b1;
			wvalid_q	<= 1'b1;
		end else begin
			if (awready_i)
				awvalid_q <= 1'b0;
			if (wready_i)
				wvalid_q <= 1'b0;
		end
	end
end

always_ff @(posedge clk) begin
	if (state == S_POP) begin
		awaddr_q	<= awfifo_data_i;
		wdata_q		<= wfifo_data_i;
		id_q		<= trk.next_id;	// still free, nothing issued since idle
	end
end

assign awfifo_rden_o	= pop_go;
assign wfifo_rden_o	= pop_go;

assign awid_o		= id_q;
assign awaddr_o		= awaddr_q;
assign awvalid_o	= awvalid_q;
assign wid_o		= id_q;
assign wdata_o		= wdata_q;
assign wvalid_o		= wvalid_q;

assign trk.issue	= issue_q;
assign trk.issue_id	= id_q;

a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
	awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o) && $stable(awid_o));

endmodule

`default_nettype wire

//--- logic/evict_resp_tracker.sv
`default_nettype none
`include "evict_macros.svh"

module evict_resp_tracker
	import evict_pkg::*;
(
	input	wire				clk,
	input	wire				rst_n,

	evict_trk_if.tracker			trk,

	// B channel
	input	wire	[`EVICT_ID_W-1:0]	bid_i,
	input	wire	[1:0]			bresp_i,
	input	wire				bvalid_i,
	output	logic				bready_o,

	output	logic	[`EVICT_OUTST_W-1:0]	outstanding_o,
	output	logic	[`EVICT_ERR_W-1:0]	err_count_o,
	output	logic				stray_o
);

localparam int NUM_IDS = 1 << `EVICT_ID_W;

logic	[NUM_IDS-1:0]		busy;
logic	[NUM_IDS-1:0]		set_mask;
logic	[NUM_IDS-1:0]		clr_mask;
logic	[`EVICT_OUTST_W-1:0]	count;
logic	[`EVICT_ERR_W-1:0]	err_cnt;
logic				bready_q;
logic				stray_q;
logic				b_fire;
logic				b_known;
logic				b_err;
axi_resp_e			bresp;

assign bresp	= axi_resp_e'(bresp_i);
assign b_fire	= bvalid_i && bready_q;
assign b_known	= busy[bid_i];
assign b_err	= (bresp == RESP_SLVERR) || (bresp == RESP_DECERR);

assign set_mask	= trk.issue ? (NUM_IDS'(1) << trk.issue_id) : '0;
assign clr_mask	= (b_fire && b_known) ? (NUM_IDS'(1) << bid_i) : '0;

// lowest free id wins
always_comb begin
	trk.next_id = '0;
	for (int i = NUM_IDS - 1; i >= 0; i--) begin
		if (!busy[i])
			trk.next_id = i[`EVICT_ID_W-1:0];
	end
end

assign trk.credit = (count < `EVICT_MAX_OUTST) && !(&busy);

always_ff @(posedge clk) begin
	if (!rst_n) begin
		busy		<= '0;
		count		<= '0;
		err_cnt		<= '0;
		bready_q	<= 1'b0;
		stray_q		<= 1'b0;
	end else begin
		bready_q	<= 1'b1;
		busy		<= (busy & ~clr_mask) | set_mask;
		case ({trk.issue, b_fire && b_known})
			2'b10:		count <= count + 1'b1;
			2'b01:		count <= count - 1'b1;
			default:	;	// both or neither
		endcase
		if (b_fire && b_err && !(&err_cnt))
			err_cnt <= err_cnt + 1'b1;	// saturates
		if (b_fire && !b_known)
			stray_q <= 1'b1;	// sticky
	end
end

assign bready_o		= bready_q;
assign outstanding_o	= count;
assign err_count_o	= err_cnt;
assign stray_o		= stray_q;

// credit gating in the issuer keeps both of these
a_outst_limit: assert property (@(posedge clk) disable iff (!rst_n)
	count <= `EVICT_MAX_OUTST);
a_issue_free_id: assert property (@(posedge clk) disable iff (!rst_n)
	trk.issue |-> !busy[trk.issue_id]);

endmodule

`default_nettype wire

//--- logic/evict_top.sv
`default_nettype none
`include "evict_macros.svh"

module evict_top (
	input	wire				clk,
	input	wire				rst_n,

	// evicted addresses from the cache
	input	wire				evict_addr_valid_i,
	input	wire	[`EVICT_ADDR_W-1:0]	evict_addr_i,
	output	logic				evict_addr_ready_o,

	// evicted line data from the cache
	input	wire				evict_data_valid_i,
	input	wire	[`EVICT_DATA_W-1:0]	evict_data_i,
	output	logic				evict_data_ready_o,

	// AW channel
	output	logic	[`EVICT_ID_W-1:0]	awid_o,
	output	logic	[`EVICT_ADDR_W-1:0]	awaddr_o,
	output	logic				awvalid_o,
	input	wire				awready_i,

	// W channel
	output	logic	[`EVICT_ID_W-1:0]	wid_o,
	output	logic	[`EVICT_DATA_W-1:0]	wdata_o,
	output	logic				wvalid_o,
	input	wire				wready_i,

	// B channel
	input	wire	[`EVICT_ID_W-1:0]	bid_i,
	input	wire	[1:0]			bresp_i,
	input	wire				bvalid_i,
	output	logic				bready_o,

	output	logic	[`EVICT_OUTST_W-1:0]	outstanding_o,
	output	logic	[`EVICT_ERR_W-1:0]	err_count_o,
	output	logic				stray_o
);

logic				addr_push;
logic				addr_rden;
logic				addr_empty;
logic	[`EVICT_ADDR_W-1:0]	addr_q;

logic				data_push;
logic				data_rden;
logic				data_empty;
logic	[`EVICT_DATA_W-1:0]	data_q;

evict_trk_if i_trk ();

// valid alone is not a push
assign addr_push = evict_addr_valid_i && evict_addr_ready_o;
assign data_push = evict_data_valid_i && evict_data_ready_o;

evict_fifo #(
	.WIDTH		(`EVICT_ADDR_W),
	.DEPTH		(`EVICT_FIFO_DEPTH)
) i_addr_fifo (
	.clk		(clk),
	.rst_n		(rst_n),
	.push_i		(addr_push),
	.push_data_i	(evict_addr_i),
	.ready_o	(evict_addr_ready_o),
	.rden_i		(addr_rden),
	.empty_o	(addr_empty),
	.data_o		(addr_q)
);

evict_fifo #(
	.WIDTH		(`EVICT_DATA_W),
	.DEPTH		(`EVICT_FIFO_DEPTH)
) i_data_fifo (
	.clk		(clk),
	.rst_n		(rst_n),
	.push_i		(data_push),
	.push_data_i	(evict_data_i),
	.ready_o	(evict_data_ready_o),
	.rden_i		(data_rden),
	.empty_o	(data_empty),
	.data_o		(data_q)
);

evict_issuer i_issuer (
	.clk		(clk),
	.rst_n		(rst_n),
	.awfifo_empty_i	(addr_empty),
	.awfifo_rden_o	(addr_rden),
	.awfifo_data_i	(addr_q),
	.wfifo_empty_i	(data_empty),
	.wfifo_rden_o	(data_rden),
	.wfifo_data_i	(data_q),
	.trk		(i_trk),
	.awid_o		(awid_o),
	.awaddr_o	(awaddr_o),
	.awvalid_o	(awvalid_o),
	.awready_i	(awready_i),
	.wid_o		(wid_o),
	.wdata_o	(wdata_o),
	.wvalid_o	(wvalid_o),
	.wready_i	(wready_i)
);

evict_resp_tracker i_tracker (
	.clk		(clk),
	.rst_n		(rst_n),
	.trk		(i_trk),
	.bid_i		(bid_i),
	.bresp_i	(bresp_i),
	.bvalid_i	(bvalid_i),
	.bready_o	(bready_o),
	.outstanding_o	(outstanding_o),
	.err_count_o	(err_count_o),
	.stray_o	(stray_o)
);

endmodule

`default_nettype wire

//--- verif/evict_axi_mem.sv
`default_nettype none
`include "evict_macros.svh"

module evict_axi_mem
	import evict_pkg::*;
#(
	parameter logic [31:0] SEED = 32'h0
) (
	input	wire				clk,
	input	wire	[`EVICT_ID_W-1:0]	awid_i,
	input	wire				awvalid_i,
	output	logic				awready_o,
	input	wire	[`EVICT_ID_W-1:0]	wid_i,
	input	wire				wvalid_i,
	output	logic				wready_o,
	output	logic	[`EVICT_ID_W-1:0]	bid_o,
	output	logic	[1:0]			bresp_o,
	output	logic				bvalid_o,
	input	wire				bready_i,
	input	wire				stray_req_i	// send one B for an idle id
);

logic	[`EVICT_ID_W-1:0]	aw_ids[$];
logic	[`EVICT_ID_W-1:0]	w_ids[$];
logic	[`EVICT_ID_W-1:0]	pend[$];	// writes waiting for their B
integer				seed;
int				stall;
int				idx;
logic				b_fire;
logic				stray_sent;

initial begin
	seed		= SEED;
	awready_o	= 1'b0;
	wready_o	= 1'b0;
	bid_o		= '0;
	bresp_o		= RESP_OKAY;
	bvalid_o	= 1'b0;
	stall		= 0;
	stray_sent	= 1'b0;
	forever begin
		@(posedge clk);
		if (awvalid_i && awready_o)
			aw_ids.push_back(awid_i);
		if (wvalid_i && wready_o)
			w_ids.push_back(wid_i);
		b_fire = bvalid_o && bready_i;
		while (aw_ids.size() > 0 && w_ids.size() > 0) begin
			pend.push_back(aw_ids.pop_front());	// write complete once both arrived
			void'(w_ids.pop_front());
		end
		#1;
		if (stall > 0) begin
			stall--;
			awready_o = 1'b0;
		end else if (($random(seed) & 63) == 0) begin
			stall = 12;	// long stall lets the FIFOs fill
			awready_o = 1'b0;
		end else begin
			awready_o = ($random(seed) & 3) != 0;
		end
		wready_o = ($random(seed) & 3) != 0;
		if (b_fire)
			bvalid_o = 1'b0;
		if (!bvalid_o) begin
			if (stray_req_i && !stray_sent && pend.size() == 0) begin
				bid_o		= `EVICT_ID_W'($random(seed));
				bresp_o		= RESP_OKAY;
				bvalid_o	= 1'b1;
				stray_sent	= 1'b1;
			end else if (pend.size() > 0 && ($random(seed) & 3) == 0) begin
				idx		= $unsigned($random(seed)) % pend.size();	// any pending id
				bid_o		= pend[idx];
				pend.delete(idx);
				bresp_o		= (($random(seed) & 7) == 0) ? RESP_SLVERR : RESP_OKAY;
				bvalid_o	= 1'b1;
			end
		end
	end
end

endmodule

`default_nettype wire

//--- verif/tb_evict_top.sv
`default_nettype none
`include "evict_macros.svh"

module tb_evict_top
	import evict_pkg::*;
();

localparam int NUM_WRITES	= 200;
localparam int TIMEOUT		= NUM_WRITES * 40 + 1000;	// cycles
localparam int NUM_IDS		= 1 << `EVICT_ID_W;

logic				clk = 1'b0;
logic				rst_n;
logic				addr_valid;
logic	[`EVICT_ADDR_W-1:0]	addr;
logic				addr_ready;
logic				data_valid;
logic	[`EVICT_DATA_W-1:0]	data;
logic				data_ready;
logic	[`EVICT_ID_W-1:0]	awid;
logic	[`EVICT_ADDR_W-1:0]	awaddr;
logic				awvalid;
logic				awready;
logic	[`EVICT_ID_W-1:0]	wid;
logic	[`EVICT_DATA_W-1:0]	wdata;
logic				wvalid;
logic				wready;
logic	[`EVICT_ID_W-1:0]	bid;
logic	[1:0]			bresp;
logic				bvalid;
logic				bready;
logic	[`EVICT_OUTST_W-1:0]	outstanding;
logic	[`EVICT_ERR_W-1:0]	err_count;
logic				stray;
logic				stray_req;
logic				stray_armed = 1'b0;

integer				seed = 32'ha99275c2;
int				addr_left = NUM_WRITES;
int				data_left = NUM_WRITES;

// model
logic	[`EVICT_ADDR_W-1:0]	addr_model[$];
logic	[`EVICT_DATA_W-1:0]	data_model[$];
logic	[`EVICT_ID_W-1:0]	aw_id_model[$];
logic	[`EVICT_ID_W-1:0]	w_id_model[$];
logic	[NUM_IDS-1:0]		id_busy = '0;
logic	[`EVICT_ADDR_W-1:0]	exp_addr;
logic	[`EVICT_DATA_W-1:0]	exp_data;
logic	[`EVICT_ID_W-1:0]	exp_id;
logic	[`EVICT_ID_W-1:0]	got_id;
int				addr_pushes = 0;
int				data_pushes = 0;
int				aw_cnt = 0;
int				w_cnt = 0;
int				outst_cnt = 0;
int				exp_err = 0;
int				errors = 0;
int				cycles = 0;
int				occ;

// values seen while a valid waited
logic				aw_wait = 1'b0;
logic				w_wait = 1'b0;
logic	[`EVICT_ADDR_W-1:0]	awaddr_prev;
logic	[`EVICT_ID_W-1:0]	awid_prev;
logic	[`EVICT_DATA_W-1:0]	wdata_prev;
logic	[`EVICT_ID_W-1:0]	wid_prev;

always #4 clk = ~clk;

evict_top i_dut (
	.clk, .rst_n,
	.evict_addr_valid_i(addr_valid), .evict_addr_i(addr), .evict_addr_ready_o(addr_ready),
	.evict_data_valid_i(data_valid), .evict_data_i(data), .evict_data_ready_o(data_ready),
	.awid_o(awid), .awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
	.wid_o(wid), .wdata_o(wdata), .wvalid_o(wvalid), .wready_i(wready),
	.bid_i(bid), .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready),
	.outstanding_o(outstanding), .err_count_o(err_count), .stray_o(stray)
);

evict_axi_mem #(.SEED(32'ha99275c2)) i_mem (
	.clk,
	.awid_i(awid), .awvalid_i(awvalid), .awready_o(awready),
	.wid_i(wid), .wvalid_i(wvalid), .wready_o(wready),
	.bid_o(bid), .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
	.stray_req_i(stray_req)
);

task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
	$display("ERR %s got %h exp %h", name, got, exp);
	errors++;
endtask

task automatic check_reset_outputs;
	if (awvalid !== 1'b0) report_mismatch("awvalid_o", awvalid, 0);
	if (wvalid !== 1'b0) report_mismatch("wvalid_o", wvalid, 0);
	if (bready !== 1'b0) report_mismatch("bready_o", bready, 0);
	if (outstanding !== '0) report_mismatch("outstanding_o", outstanding, 0);
	if (err_count !== '0) report_mismatch("err_count_o", err_count, 0);
	if (stray !== 1'b0) report_mismatch("stray_o", stray, 0);
	if (addr_ready !== 1'b1) report_mismatch("evict_addr_ready_o", addr_ready, 1);
	if (data_ready !== 1'b1) report_mismatch("evict_data_ready_o", data_ready, 1);
endtask

// cache side pushes, address and data independent
initial begin
	logic addr_fire;
	logic data_fire;
	logic run;
	addr_valid = 1'b0;
	addr = '0;
	data_valid = 1'b0;
	data = '0;
	forever begin
		@(posedge clk);
		addr_fire = addr_valid && addr_ready;
		data_fire = data_valid && data_ready;
		run = rst_n;	// reset as seen at this edge
		#1;
		if (addr_fire) begin
			addr_valid = 1'b0;
			addr_left--;
		end
		if (data_fire) begin
			data_valid = 1'b0;
			data_left--;
		end
		if (run && !addr_valid && addr_left > 0 && ($random(seed) & 3) != 0) begin
			addr_valid = 1'b1;
			addr = $random(seed) & 32'hffff_ffc0;	// line aligned
		end
		if (run && !data_valid && data_left > 0 && ($random(seed) & 3) != 0) begin
			data_valid = 1'b1;
			data = {$random(seed), $random(seed)};
		end
	end
end

always @(posedge clk) begin
	if (rst_n) begin
		// fill level is exact while the issuer holds a popped pair
		if (awvalid) begin
			occ = addr_pushes - aw_cnt - 1;
			if (addr_ready !== (occ < `EVICT_FIFO_DEPTH))
				report_mismatch("evict_addr_ready_o", addr_ready, occ < `EVICT_FIFO_DEPTH);
		end
		if (wvalid) begin
			occ = data_pushes - w_cnt - 1;
			if (data_ready !== (occ < `EVICT_FIFO_DEPTH))
				report_mismatch("evict_data_ready_o", data_ready, occ < `EVICT_FIFO_DEPTH);
		end
		if (aw_wait) begin
			if (!awvalid) begin
				$display("awvalid_o dropped while waiting for awready");
				errors++;
			end
			if (awaddr !== awaddr_prev) report_mismatch("awaddr_o", awaddr, awaddr_prev);
			if (awid !== awid_prev) report_mismatch("awid_o", awid, awid_prev);
		end
		if (w_wait) begin
			if (!wvalid) begin
				$display("wvalid_o dropped while waiting for wready");
				errors++;
			end
			if (wdata !== wdata_prev) report_mismatch("wdata_o", wdata, wdata_prev);
			if (wid !== wid_prev) report_mismatch("wid_o", wid, wid_prev);
		end
		if (int'(outstanding) > `EVICT_MAX_OUTST)
			report_mismatch("outstanding_o", outstanding, `EVICT_MAX_OUTST);
		if (!stray_armed && stray !== 1'b0)
			report_mismatch("stray_o", stray, 0);
		if (addr_valid && addr_ready) begin
			addr_model.push_back(addr);
			addr_pushes++;
		end
		if (data_valid && data_ready) begin
			data_model.push_back(data);
			data_pushes++;
		end
		if (awvalid && awready) begin
			if (addr_model.size() == 0) begin
				$display("AW accepted with no pushed address left");
				errors++;
			end else begin
				exp_addr = addr_model.pop_front();
				if (awaddr !== exp_addr) report_mismatch("awaddr_o", awaddr, exp_addr);
			end
			if (id_busy[awid]) begin
				$display("AW accepted with ID %h still awaiting its B", awid);
				errors++;
			end
			id_busy[awid] = 1'b1;
			outst_cnt++;
			aw_id_model.push_back(awid);
			aw_cnt++;
		end
		if (wvalid && wready) begin
			if (data_model.size() == 0) begin
				$display("W accepted with no pushed data left");
				errors++;
			end else begin
				exp_data = data_model.pop_front();
				if (wdata !== exp_data) report_mismatch("wdata_o", wdata, exp_data);
			end
			w_id_model.push_back(wid);
			w_cnt++;
		end
		// AW and W of one write may finish in either order
		while (aw_id_model.size() > 0 && w_id_model.size() > 0) begin
			exp_id = aw_id_model.pop_front();
			got_id = w_id_model.pop_front();
			if (got_id !== exp_id) report_mismatch("wid_o", got_id, exp_id);
		end
		if (bvalid && bready) begin
			if (bresp == RESP_SLVERR || bresp == RESP_DECERR)
				exp_err++;
			if (id_busy[bid]) begin
				id_busy[bid] = 1'b0;
				outst_cnt--;
			end else if (!stray_armed) begin
				$display("B returned for ID %h that was not outstanding", bid);
				errors++;
			end
		end
		aw_wait = awvalid && !awready;
		w_wait = wvalid && !wready;
		awaddr_prev = awaddr;
		awid_prev = awid;
		wdata_prev = wdata;
		wid_prev = wid;
	end
end

always @(posedge clk) begin
	cycles++;
	if (cycles > TIMEOUT) begin
		$display("timeout, run did not finish within %0d cycles", TIMEOUT);
		$display("writes %0d, injected errors %0d, check errors %0d", w_cnt, exp_err, errors);
		$display(">>> FAIL");
		$finish;
	end
end

initial begin
	rst_n = 1'b0;
	stray_req = 1'b0;
	repeat (10) @(posedge clk);
	#1;
	check_reset_outputs();
	rst_n = 1'b1;
	while (w_cnt < NUM_WRITES || aw_cnt < NUM_WRITES || outst_cnt != 0)
		@(negedge clk);
	repeat (2) @(negedge clk);
	if (outstanding !== '0) report_mismatch("outstanding_o", outstanding, 0);
	if (err_count !== `EVICT_ERR_W'(exp_err))
		report_mismatch("err_count_o", err_count, exp_err);
	if (addr_model.size() != 0 || data_model.size() != 0) begin
		$display("pushed entries left over after all writes finished");
		errors++;
	end
	@(posedge clk);
	#1;
	stray_armed = 1'b1;
	stray_req = 1'b1;
	while (stray !== 1'b1)
		@(negedge clk);
	$display("writes %0d, injected errors %0d, err_count_o %0d, check errors %0d",
		w_cnt, exp_err, err_count, errors);
	if (errors == 0) begin
		$display(">>> PASS");
	end else begin
		$display(">>> FAIL");
	end
	$finish;
end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/evict_pkg.sv
logic/evict_trk_if.sv
logic/evict_fifo.sv
logic/evict_issuer.sv
logic/evict_resp_tracker.sv
logic/evict_top.sv
verif/evict_axi_mem.sv
verif/tb_evict_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module tb_evict_top -Mdir obj_dir

out=$(./obj_dir/Vtb_evict_top)
echo "$out"

if echo "$out" | grep -qxF '>>> PASS'; then
	exit 0
fi
exit 1
